// ==== files.f ====
rtl/sms_mem_pkg.sv
rtl/sms_ctrl_pkg.sv
rtl/ce_divider.sv
rtl/cart_loader.sv
rtl/cheat_assembler.sv
rtl/save_ram_control.sv
rtl/sms_host_glue.sv
verif/sms_host_glue_tb.sv

// ==== rtl/cart_loader.sv ====
// Cartridge byte writer, size mask tracking and console ROM address translation
`default_nettype none

module cart_loader (
	input  logic                             clk_sys,
	input  logic                             arst_n,
	input  logic                             cart_active,
	input  logic [sms_mem_pkg::BYTE_W-1:0]   ioctl_index,
	input  logic [sms_mem_pkg::IOCTL_AW-1:0] ioctl_addr,
	input  logic [sms_mem_pkg::BYTE_W-1:0]   ioctl_dout,
	input  logic                             ioctl_wr,
	input  logic                             rom_wr_ack_tog,
	input  logic [sms_mem_pkg::ROM_AW-1:0]   console_raddr,
	output logic                             ioctl_wait,
	output logic [sms_mem_pkg::ROM_AW-1:0]   rom_waddr,
	output logic [sms_mem_pkg::BYTE_W-1:0]   rom_wdata,
	output logic                             rom_wr_tog,
	output logic [sms_mem_pkg::ROM_AW-1:0]   rom_raddr,
	output logic                             game_gear
);
	import sms_mem_pkg::*;

	localparam logic [ROM_AW-1:0]   HDR_ROM   = ROM_AW'(HEADER_BYTES);
	localparam logic [IOCTL_AW-1:0] HDR_IOCTL = IOCTL_AW'(HEADER_BYTES);

	logic              cart_prev;
	logic              byte_wr;
	logic [ROM_AW-1:0] wr_addr;
	logic [ROM_AW-1:0] last_addr;   // Address of the latest byte
	logic [ROM_AW-1:0] end_addr;    // Image size once the download ends
	logic [ROM_AW-1:0] cart_mask;
	logic [ROM_AW-1:0] cart_mask512;
	logic              cart_hdr;

	assign byte_wr  = ioctl_wr & cart_active;
	assign wr_addr  = ioctl_addr[ROM_AW-1:0];
	assign end_addr = last_addr + 1'b1;

	// ==============================
	// Toggle handshake to ROM memory
	// ==============================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_prev  <= 1'b0;
			ioctl_wait <= 1'b0;
			rom_wr_tog <= 1'b0;
			rom_waddr  <= '0;
		end else begin
			cart_prev <= cart_active;
			if (byte_wr) begin
				ioctl_wait <= 1'b1;           // Hold host until stored
				rom_wr_tog <= ~rom_wr_tog;
			end else if (ioctl_wait && rom_wr_tog == rom_wr_ack_tog) begin
				ioctl_wait <= 1'b0;
				rom_waddr  <= rom_waddr + 1'b1;
			end
			if (cart_active && !cart_prev)
				rom_waddr <= '0; // New image
		end
	end

	always_ff @(posedge clk_sys) begin
		if (byte_wr)
			rom_wdata <= ioctl_dout;
	end

	// Masks grow with the highest address seen
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_mask    <= '0;
			cart_mask512 <= '0;
			last_addr    <= '0;
			game_gear    <= 1'b0;
			cart_hdr     <= 1'b0;
		end else begin
			if (byte_wr) begin
				cart_mask <= (ioctl_addr == '0) ? '0 : cart_mask | wr_addr;
				cart_mask512 <= (ioctl_addr == HDR_IOCTL) ? '0 :
					cart_mask512 | (wr_addr - HDR_ROM);
				last_addr <= wr_addr;
				game_gear <= ioctl_index[4:0] == GG_INDEX;
			end
			// Odd number of sectors means a header in front
			if (cart_prev && !cart_active)
				cart_hdr <= end_addr[BUF_AW];
		end
	end

	assign rom_raddr = cart_hdr ? (console_raddr + HDR_ROM) & cart_mask512 :
		console_raddr & cart_mask;

endmodule

`default_nettype wire

// ==== rtl/ce_divider.sv ====
// Clock enables for CPU, VDP, pixel and sprite logic from a divide-by-30 count
`default_nettype none

module ce_divider (
	input  logic clk_sys,
	input  logic arst_n,
	output logic ce_cpu,
	output logic ce_vdp,
	output logic ce_pix,
	output logic ce_sp
);

	localparam logic [4:0] DIV_LAST = 5'd29;

	logic [4:0] clkd; // Phase within the 30-cycle frame

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			clkd   <= '0;
			ce_cpu <= 1'b0;
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_sp  <= 1'b0;
		end else begin
			clkd  <= (clkd == DIV_LAST) ? 5'd0 : clkd + 5'd1;
			ce_sp <= clkd[0]; // Half rate, 30 is even so no slip at wrap

			// VDP /5, pixel /10, CPU /15
			ce_vdp <= 1'b0;
			ce_pix <= 1'b0;
			ce_cpu <= 1'b0;
			case (clkd)
				5'd4, 5'd14: ce_vdp <= 1'b1;
				5'd9: begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
					ce_cpu <= 1'b1;
				end
				5'd19, 5'd29: begin
					ce_vdp <= 1'b1;
					ce_pix <= 1'b1;
				end
				5'd24: begin
					ce_vdp <= 1'b1;
					ce_cpu <= 1'b1; // Late CPU phase keeps HCounter timing
				end
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/cheat_assembler.sv ====
// Cheat record collector: flag, address, compare and replace words with valid pulse
`default_nettype none

module cheat_assembler (
	input  logic                             clk_sys,
	input  logic                             arst_n,
	input  logic                             code_active,
	input  logic [3:0]                       ioctl_addr,
	input  logic [sms_mem_pkg::BYTE_W-1:0]   ioctl_dout,
	input  logic                             ioctl_wr,
	output logic [4*sms_mem_pkg::BYTE_W-1:0] code_flags,
	output logic [4*sms_mem_pkg::BYTE_W-1:0] code_addr,
	output logic [4*sms_mem_pkg::BYTE_W-1:0] code_compare,
	output logic [4*sms_mem_pkg::BYTE_W-1:0] code_replace,
	output logic                             code_valid
);
	import sms_mem_pkg::*;

	localparam logic [3:0] LAST_BYTE = 4'd15;

	logic       byte_wr;
	logic [1:0] lane;     // Byte lane in the word, LSB first

	assign byte_wr = code_active & ioctl_wr;
	assign lane    = ioctl_addr[1:0];

	// Record is 4 little-endian words
	always_ff @(posedge clk_sys) begin
		if (byte_wr) begin
			case (ioctl_addr[3:2])
				2'd0: code_flags[lane*BYTE_W +: BYTE_W]   <= ioctl_dout;
				2'd1: code_addr[lane*BYTE_W +: BYTE_W]    <= ioctl_dout;
				2'd2: code_compare[lane*BYTE_W +: BYTE_W] <= ioctl_dout;
				default: code_replace[lane*BYTE_W +: BYTE_W] <= ioctl_dout;
			endcase
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n)
			code_valid <= 1'b0;
		else
			code_valid <= byte_wr && ioctl_addr == LAST_BYTE; // Record complete
	end

endmodule

`default_nettype wire

// ==== rtl/save_ram_control.sv ====
// Download decoding, core reset, backup enable and backup RAM sector sequencer
`default_nettype none

module save_ram_control #(
	parameter int BK_SECTORS = 64
) (
	input  logic                           clk_sys,
	input  logic                           arst_n,
	input  logic                           reset_req,
	input  logic                           ioctl_download,
	input  logic [sms_mem_pkg::BYTE_W-1:0] ioctl_index,
	input  logic                           bk_load_req,
	input  logic                           bk_save_req,
	input  logic                           autosave_en,
	input  logic                           osd_open,
	input  logic                           img_mounted,
	input  logic                           img_readonly,
	input  logic                           img_size_nz,
	input  logic                           nvram_we,
	input  logic                           sd_ack,
	output logic                           cart_active,
	output logic                           code_active,
	output logic [sms_mem_pkg::LBA_W-1:0]  sd_lba,
	output logic                           sd_rd,
	output logic                           sd_wr,
	output logic                           bk_busy,
	output logic                           bk_pending,
	output logic                           core_reset
);
	import sms_mem_pkg::*;
	import sms_ctrl_pkg::*;

	localparam logic [LBA_W-1:0] LBA_LAST = LBA_W'(BK_SECTORS - 1);

	bk_state_e state;
	sd_cmd_e   cmd;
	logic      cart_prev;
	logic      bk_ena;
	logic      loading;
	logic      save_req;
	logic      load_lvl;
	logic      save_lvl;
	logic      load_prev;
	logic      save_prev;
	logic      dl_done;
	logic      start_xfer;
	logic      start_load;

	assign code_active = ioctl_download & (ioctl_index == CODE_INDEX);
	assign cart_active = ioctl_download & (ioctl_index != CODE_INDEX);

	// Pending data with menu open counts as a save press when autosave is on
	assign save_req   = bk_save_req | (bk_pending & osd_open & autosave_en);
	assign load_lvl   = bk_load_req & bk_ena;
	assign save_lvl   = save_req & bk_ena;
	assign dl_done    = cart_prev & ~cart_active & img_size_nz & bk_ena;
	assign start_load = dl_done | (load_lvl & ~load_prev);
	assign start_xfer = (state == BK_IDLE) & (start_load | (save_lvl & ~save_prev));

	assign sd_rd      = cmd == SD_READ;
	assign sd_wr      = cmd == SD_WRITE;
	assign bk_busy    = state != BK_IDLE;
	assign core_reset = ~arst_n | reset_req | cart_active | loading;

	// ==============================
	// Enable and pending flags
	// ==============================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_prev  <= 1'b0;
			load_prev  <= 1'b0;
			save_prev  <= 1'b0;
			bk_ena     <= 1'b0;
			bk_pending <= 1'b0;
		end else begin
			cart_prev <= cart_active;
			load_prev <= load_lvl;
			save_prev <= save_lvl;
			if (cart_active && !cart_prev)
				bk_ena <= 1'b0;
			// Save file gets mounted while the image still loads
			if (cart_active && img_mounted && !img_readonly)
				bk_ena <= 1'b1;
			if (bk_ena && !osd_open && nvram_we)
				bk_pending <= 1'b1;
			else if (start_xfer)
				bk_pending <= 1'b0;
		end
	end

	// ==============================
	// Sector sequencer
	// ==============================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			state   <= BK_IDLE;
			cmd     <= SD_NONE;
			loading <= 1'b0;
			sd_lba  <= '0;
		end else begin
			case (state)
				BK_IDLE: if (start_xfer) begin
					state   <= BK_CMD;
					loading <= start_load;
					sd_lba  <= '0;
					cmd     <= start_load ? SD_READ : SD_WRITE;
				end
				BK_CMD: if (sd_ack) begin
					cmd   <= SD_NONE; // Host took the command
					state <= BK_XFER;
				end
				BK_XFER: if (!sd_ack) begin
					if (sd_lba == LBA_LAST) begin
						state   <= BK_IDLE;
						loading <= 1'b0;
					end else begin
						sd_lba <= sd_lba + 1'b1;
						cmd    <= loading ? SD_READ : SD_WRITE;
						state  <= BK_CMD;
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== rtl/sms_ctrl_pkg.sv ====
// Backup sequencer state type and sector command type
`default_nettype none

package sms_ctrl_pkg;

	// ==============================
	// Backup RAM sequencer
	// ==============================
	typedef enum logic [1:0] {
		BK_IDLE = 2'd0, // No transfer
		BK_CMD  = 2'd1, // Command raised, waiting for ack
		BK_XFER = 2'd2  // Host moving the sector
	} bk_state_e;

	// Command level on the sector port
	typedef enum logic [1:0] {
		SD_NONE  = 2'd0,
		SD_READ  = 2'd1,
		SD_WRITE = 2'd2
	} sd_cmd_e;

endpackage

`default_nettype wire

// ==== rtl/sms_host_glue.sv ====
// Host glue top: clock enables, cartridge loader, cheat collector, backup control
`default_nettype none

module sms_host_glue #(
	parameter int BK_SECTORS = 64
) (
	input  logic                             clk_sys,
	input  logic                             arst_n,
	input  logic                             reset_req,
	// Download port
	input  logic                             ioctl_download,
	input  logic [sms_mem_pkg::BYTE_W-1:0]   ioctl_index,
	input  logic [sms_mem_pkg::IOCTL_AW-1:0] ioctl_addr,
	input  logic [sms_mem_pkg::BYTE_W-1:0]   ioctl_dout,
	input  logic                             ioctl_wr,
	output logic                             ioctl_wait,
	// ROM memory
	output logic [sms_mem_pkg::ROM_AW-1:0]   rom_waddr,
	output logic [sms_mem_pkg::BYTE_W-1:0]   rom_wdata,
	output logic                             rom_wr_tog,
	input  logic                             rom_wr_ack_tog,
	input  logic [sms_mem_pkg::ROM_AW-1:0]   console_raddr,
	output logic [sms_mem_pkg::ROM_AW-1:0]   rom_raddr,
	output logic                             game_gear,
	// Cheat code
	output logic [4*sms_mem_pkg::BYTE_W-1:0] code_flags,
	output logic [4*sms_mem_pkg::BYTE_W-1:0] code_addr,
	output logic [4*sms_mem_pkg::BYTE_W-1:0] code_compare,
	output logic [4*sms_mem_pkg::BYTE_W-1:0] code_replace,
	output logic                             code_valid,
	// Backup RAM
	input  logic                             bk_load_req,
	input  logic                             bk_save_req,
	input  logic                             autosave_en,
	input  logic                             osd_open,
	input  logic                             img_mounted,
	input  logic                             img_readonly,
	input  logic                             img_size_nz,
	input  logic                             nvram_we,
	output logic [sms_mem_pkg::LBA_W-1:0]    sd_lba,
	output logic                             sd_rd,
	output logic                             sd_wr,
	input  logic                             sd_ack,
	output logic                             bk_busy,
	output logic                             bk_pending,
	output logic                             core_reset,
	// Clock enables
	output logic                             ce_cpu,
	output logic                             ce_vdp,
	output logic                             ce_pix,
	output logic                             ce_sp
);

	logic cart_active;
	logic code_active;

	save_ram_control #(
		.BK_SECTORS(BK_SECTORS)
	) save_ram_control_i (
		.clk_sys, .arst_n, .reset_req, .ioctl_download, .ioctl_index,
		.bk_load_req, .bk_save_req, .autosave_en, .osd_open,
		.img_mounted, .img_readonly, .img_size_nz, .nvram_we, .sd_ack,
		.cart_active, .code_active, .sd_lba, .sd_rd, .sd_wr,
		.bk_busy, .bk_pending, .core_reset
	);

	ce_divider ce_divider_i (
		.clk_sys, .arst_n, .ce_cpu, .ce_vdp, .ce_pix, .ce_sp
	);

	cart_loader cart_loader_i (
		.clk_sys, .arst_n, .cart_active, .ioctl_index, .ioctl_addr,
		.ioctl_dout, .ioctl_wr, .rom_wr_ack_tog, .console_raddr,
		.ioctl_wait, .rom_waddr, .rom_wdata, .rom_wr_tog, .rom_raddr,
		.game_gear
	);

	// Only the byte position within a 16-byte record matters
	cheat_assembler cheat_assembler_i (
		.clk_sys,
		.arst_n,
		.code_active,
		.ioctl_addr (ioctl_addr[3:0]),
		.ioctl_dout,
		.ioctl_wr,
		.code_flags,
		.code_addr,
		.code_compare,
		.code_replace,
		.code_valid
	);

endmodule

`default_nettype wire

// ==== rtl/sms_mem_pkg.sv ====
// Widths and sizes for download, ROM, cheat and backup sector paths
`default_nettype none

package sms_mem_pkg;

	// ==============================
	// Bus widths
	// ==============================
	localparam int ROM_AW   = 22; // Console ROM space, 4 MiB
	localparam int IOCTL_AW = 25; // Host download address
	localparam int BYTE_W   = 8;
	localparam int LBA_W    = 32; // Sector number on the host port
	localparam int BUF_AW   = 9;  // Byte address inside one sector

	// ==============================
	// Image format
	// ==============================
	// Copier header in front of some images, one sector long
	localparam int HEADER_BYTES = 512;

	// Download index decoding
	localparam logic [BYTE_W-1:0] CODE_INDEX = 8'hFF; // Cheat file
	localparam logic [4:0]        GG_INDEX   = 5'd2;  // Handheld image

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Build the host glue testbench with Verilator, run it and scan the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing -j 0 --top-module sms_host_glue_tb -f files.f -o sms_host_glue_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sms_host_glue_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "STATUS: FAIL" "$LOG"; then
	exit 1
fi
exit 0

// ==== verif/sms_host_glue_tb.sv ====
// Host glue testbench with clock, xorshift stimulus, ROM and sector models and checks
`default_nettype none

module sms_host_glue_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import sms_mem_pkg::*;

	localparam int BK_SECTORS = 64;

	// ==============================
	// Run length limit
	// ==============================
	localparam int MAX_BYTES   = 79 + 1024 + 1536 + 16; // Random cart, two mask carts, cheat
	localparam int BYTE_CYC    = 8;  // Strobe, toggle, up to 5 memory cycles, wait fall
	localparam int SECTOR_CYC  = 12; // Command, up to 8 ack cycles, reissue
	localparam int CYCLE_LIMIT = MAX_BYTES * BYTE_CYC + 3 * BK_SECTORS * SECTOR_CYC + 2000;

	logic                clk_sys = 1'b0;
	logic                arst_n;
	logic                reset_req;
	logic                ioctl_download;
	logic [BYTE_W-1:0]   ioctl_index;
	logic [IOCTL_AW-1:0] ioctl_addr;
	logic [BYTE_W-1:0]   ioctl_dout;
	logic                ioctl_wr;
	logic                ioctl_wait;
	logic [ROM_AW-1:0]   rom_waddr;
	logic [BYTE_W-1:0]   rom_wdata;
	logic                rom_wr_tog;
	logic                rom_wr_ack_tog = 1'b0;
	logic [ROM_AW-1:0]   console_raddr;
	logic [ROM_AW-1:0]   rom_raddr;
	logic                game_gear;
	logic [31:0]         code_flags;
	logic [31:0]         code_addr;
	logic [31:0]         code_compare;
	logic [31:0]         code_replace;
	logic                code_valid;
	logic                bk_load_req;
	logic                bk_save_req;
	logic                autosave_en;
	logic                osd_open;
	logic                img_mounted;
	logic                img_readonly;
	logic                img_size_nz;
	logic                nvram_we;
	logic [LBA_W-1:0]    sd_lba;
	logic                sd_rd;
	logic                sd_wr;
	logic                sd_ack = 1'b0;
	logic                bk_busy;
	logic                bk_pending;
	logic                core_reset;
	logic                ce_cpu;
	logic                ce_vdp;
	logic                ce_pix;
	logic                ce_sp;

	logic [31:0]       rng_state = 32'h7ce7_353e;
	int                value_errs = 0;
	int                other_errs = 0;
	int                cycles = 0;
	int                valid_cnt = 0;
	int                mem_delay = 0;
	logic              mem_pend = 1'b0;
	int                ack_left = 0;
	logic [ROM_AW-1:0] wr_addr_q[$]; // ROM writes seen by the memory model
	logic [BYTE_W-1:0] wr_data_q[$];
	logic [1:0]        cmd_q[$];     // {sd_wr, sd_rd} per sector command
	logic [LBA_W-1:0]  lba_q[$];

	sms_host_glue #(
		.BK_SECTORS(BK_SECTORS)
	) sms_host_glue_i (.*);

	initial begin
		forever #5 clk_sys = ~clk_sys;
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic value_mismatch(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		value_errs++;
		$display("FAILED %s expected 0x%0h actual 0x%0h at %0t", name, exp, act, $time);
	endtask

	task automatic protocol_error(input string what);
		other_errs++;
		$display("Error at %0t: %s", $time, what);
	endtask

	// ==============================
	// ROM memory and host sector models
	// ==============================
	always @(negedge clk_sys) begin
		if (mem_pend) begin
			if (mem_delay == 0) begin
				rom_wr_ack_tog = rom_wr_tog; // Byte stored
				mem_pend = 1'b0;
			end else begin
				mem_delay--;
			end
		end else if (rom_wr_tog != rom_wr_ack_tog) begin
			wr_addr_q.push_back(rom_waddr);
			wr_data_q.push_back(rom_wdata);
			mem_delay = int'(next_rand() % 32'd6);
			mem_pend = 1'b1;
		end
	end

	always @(negedge clk_sys) begin
		if (ack_left > 0) begin
			ack_left--;
			if (ack_left == 0)
				sd_ack = 1'b0;
		end else if (sd_rd || sd_wr) begin
			cmd_q.push_back({sd_wr, sd_rd});
			lba_q.push_back(sd_lba);
			sd_ack = 1'b1;
			ack_left = 1 + int'(next_rand() % 32'd8); // Sector takes 1 to 8 cycles
		end
	end

	always @(negedge clk_sys) begin
		if (code_valid)
			valid_cnt++;
	end

	initial begin
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clk_sys);
			cycles++;
		end
		$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("STATUS: FAIL");
		$finish;
	end

	// ==============================
	// Test tasks
	// ==============================
	task automatic check_enables();
		logic [3:0] ce_log[300];
		int i;
		int j;
		int n_cpu;
		int n_vdp;
		int n_pix;
		int n_sp;
		for (i = 0; i < 300; i++) begin
			@(negedge clk_sys);
			ce_log[i] = {ce_cpu, ce_vdp, ce_pix, ce_sp};
		end
		for (i = 0; i <= 270; i++) begin
			n_cpu = 0;
			n_vdp = 0;
			n_pix = 0;
			n_sp = 0;
			for (j = i; j < i + 30; j++) begin
				if (ce_log[j][3])
					n_cpu++;
				if (ce_log[j][2])
					n_vdp++;
				if (ce_log[j][1])
					n_pix++;
				if (ce_log[j][0])
					n_sp++;
			end
			if (n_cpu != 2)
				value_mismatch("ce_cpu count", 2, n_cpu);
			if (n_vdp != 6)
				value_mismatch("ce_vdp count", 6, n_vdp);
			if (n_pix != 3)
				value_mismatch("ce_pix count", 3, n_pix);
			if (n_sp != 15)
				value_mismatch("ce_sp count", 15, n_sp);
		end
	endtask

	// Starts on a falling edge and returns on the first falling edge with ioctl_wait low
	task automatic write_byte(input logic [IOCTL_AW-1:0] addr, input logic [BYTE_W-1:0] data,
		input logic expect_wait);
		ioctl_addr = addr;
		ioctl_dout = data;
		ioctl_wr = 1'b1;
		@(negedge clk_sys);
		ioctl_wr = 1'b0;
		if (ioctl_wait != expect_wait)
			value_mismatch("ioctl_wait", 32'(expect_wait), 32'(ioctl_wait));
		while (ioctl_wait)
			@(negedge clk_sys);
		if (rom_wr_tog != rom_wr_ack_tog)
			protocol_error("ioctl_wait fell while a ROM write was still outstanding");
	endtask

	task automatic cart_download(input int len, input logic [BYTE_W-1:0] idx);
		logic [BYTE_W-1:0] sent[$];
		logic [BYTE_W-1:0] data;
		int base;
		int i;
		base = wr_addr_q.size();
		ioctl_index = idx;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (i = 0; i < len; i++) begin
			data = BYTE_W'(next_rand());
			sent.push_back(data);
			write_byte(IOCTL_AW'(i), data, 1'b1);
		end
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		if (wr_addr_q.size() - base != len) begin
			protocol_error($sformatf("%0d ROM writes seen for %0d bytes sent",
				wr_addr_q.size() - base, len));
		end else begin
			for (i = 0; i < len; i++) begin
				if (wr_addr_q[base + i] != ROM_AW'(i))
					value_mismatch("rom_waddr", 32'(i), 32'(wr_addr_q[base + i]));
				if (wr_data_q[base + i] != sent[i])
					value_mismatch("rom_wdata", 32'(sent[i]), 32'(wr_data_q[base + i]));
			end
		end
		if (game_gear != (idx[4:0] == GG_INDEX))
			value_mismatch("game_gear", 32'(idx[4:0] == GG_INDEX), 32'(game_gear));
	endtask

	task automatic check_translation(input int len);
		logic [ROM_AW-1:0] mask;
		logic [ROM_AW-1:0] mask512;
		logic [ROM_AW-1:0] addr;
		logic [ROM_AW-1:0] exp;
		logic              hdr;
		int i;
		mask = '0;
		mask512 = '0;
		for (i = 0; i < len; i++) begin
			mask = mask | ROM_AW'(i);
			if (i >= HEADER_BYTES)
				mask512 = mask512 | ROM_AW'(i - HEADER_BYTES);
		end
		hdr = ((len / HEADER_BYTES) % 2) == 1; // Odd count of 512-byte blocks
		for (i = 0; i < 24; i++) begin
			addr = ROM_AW'(next_rand());
			console_raddr = addr;
			exp = hdr ? (addr + ROM_AW'(HEADER_BYTES)) & mask512 : addr & mask;
			@(negedge clk_sys);
			if (rom_raddr != exp)
				value_mismatch("rom_raddr", 32'(exp), 32'(rom_raddr));
		end
	endtask

	task automatic cheat_download();
		logic [BYTE_W-1:0] rec[16];
		logic [31:0]       exp_word[4];
		int valid_before;
		int writes_before;
		int i;
		valid_before = valid_cnt;
		writes_before = wr_addr_q.size();
		ioctl_index = CODE_INDEX;
		ioctl_download = 1'b1;
		@(negedge clk_sys);
		for (i = 0; i < 16; i++) begin
			rec[i] = BYTE_W'(next_rand());
			write_byte(IOCTL_AW'(i), rec[i], 1'b0);
		end
		ioctl_download = 1'b0;
		repeat (2) @(negedge clk_sys);
		if (valid_cnt - valid_before != 1)
			protocol_error($sformatf("%0d code_valid pulses for one record",
				valid_cnt - valid_before));
		if (wr_addr_q.size() != writes_before)
			protocol_error("Cheat download wrote to ROM memory");
		// Four words with the least significant byte first
		for (i = 0; i < 4; i++)
			exp_word[i] = {rec[4*i+3], rec[4*i+2], rec[4*i+1], rec[4*i]};
		if (code_flags != exp_word[0])
			value_mismatch("code_flags", exp_word[0], code_flags);
		if (code_addr != exp_word[1])
			value_mismatch("code_addr", exp_word[1], code_addr);
		if (code_compare != exp_word[2])
			value_mismatch("code_compare", exp_word[2], code_compare);
		if (code_replace != exp_word[3])
			value_mismatch("code_replace", exp_word[3], code_replace);
	endtask

	task automatic backup_transfer(input logic load, input logic autosave);
		logic [1:0] kind;
		int base;
		int i;
		base = cmd_q.size();
		kind = load ? 2'b01 : 2'b10;
		if (autosave) begin
			autosave_en = 1'b1;
			osd_open = 1'b1;
		end else if (load) begin
			bk_load_req = 1'b1;
		end else begin
			bk_save_req = 1'b1;
		end
		@(negedge clk_sys);
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		if (!bk_busy)
			protocol_error("Backup transfer did not start after the request");
		if (bk_pending)
			value_mismatch("bk_pending", 0, 32'(bk_pending));
		while (bk_busy) begin
			if (core_reset != load)
				value_mismatch("core_reset", 32'(load), 32'(core_reset));
			@(negedge clk_sys);
		end
		if (cmd_q.size() - base != BK_SECTORS) begin
			protocol_error($sformatf("%0d sector commands instead of %0d",
				cmd_q.size() - base, BK_SECTORS));
		end else begin
			for (i = 0; i < BK_SECTORS; i++) begin
				if (cmd_q[base + i] != kind)
					value_mismatch("sd_wr/sd_rd", 32'(kind), 32'(cmd_q[base + i]));
				if (lba_q[base + i] != LBA_W'(i))
					value_mismatch("sd_lba", 32'(i), lba_q[base + i]);
			end
		end
		if (sd_rd || sd_wr)
			protocol_error("Sector command still raised after the transfer ended");
		osd_open = 1'b0;
		autosave_en = 1'b0;
	endtask

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		logic [31:0]       r;
		logic [BYTE_W-1:0] idx;
		reset_req = 1'b0;
		ioctl_download = 1'b0;
		ioctl_index = '0;
		ioctl_addr = '0;
		ioctl_dout = '0;
		ioctl_wr = 1'b0;
		console_raddr = '0;
		bk_load_req = 1'b0;
		bk_save_req = 1'b0;
		autosave_en = 1'b0;
		osd_open = 1'b0;
		img_mounted = 1'b1; // Writable save image lets backup get enabled
		img_readonly = 1'b0;
		img_size_nz = 1'b0;
		nvram_we = 1'b0;
		arst_n = 1'b0;
		repeat (4) @(negedge clk_sys);
		arst_n = 1'b1;
		if (sd_rd || sd_wr || bk_busy || bk_pending || ioctl_wait)
			protocol_error("Outputs not idle after reset");

		check_enables();

		r = next_rand();
		idx = r[7:0];
		if (r[8])
			idx[4:0] = GG_INDEX;
		if (idx == CODE_INDEX)
			idx = 8'h01;
		cart_download(16 + int'(next_rand() % 32'd64), idx);
		cart_download(1024, 8'h01);
		check_translation(1024);
		cart_download(HEADER_BYTES + 1024, 8'h02);
		check_translation(HEADER_BYTES + 1024);

		cheat_download();

		backup_transfer(1'b0, 1'b0);
		backup_transfer(1'b1, 1'b0);

		// Console write with the menu closed before the menu opens
		nvram_we = 1'b1;
		@(negedge clk_sys);
		nvram_we = 1'b0;
		if (!bk_pending)
			value_mismatch("bk_pending", 1, 32'(bk_pending));
		backup_transfer(1'b0, 1'b1);

		$display("Summary: %0d value errors, %0d other errors", value_errs, other_errs);
		if (value_errs + other_errs == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
